/* source/lb_slave_defs.svh */
// ==========================================================
// Local-bus slave widths, reset values and fixed read words
// ==========================================================
`ifndef LB_SLAVE_DEFS_SVH
`define LB_SLAVE_DEFS_SVH

// Host bus widths
`define LB_ADDR_W 24
`define LB_DATA_W 32

// Mirror memory holds 2**MIRROR_AW words
`define MIRROR_AW 5

// LED PWM counter, its carry is the uptime tick
`define LED_CW 10

// Reset value of the misc configuration register
`define MISC_DEFAULT 8'h5A

// Identification words, read in order they spell a greeting
`define HELLO_0 "Hell"
`define HELLO_1 "o wo"
`define HELLO_2 "rld!"
`define HELLO_3 "(::)"

// Returned for unused bank slots and unmapped regions
`define BANK_FILL "zzzz"
`define REGION_FILL 32'hdeadbeef

`endif

/* source/lb_map_pkg.sv */
// ==========================================================
// Local-bus address map: regions, bank and write registers
// ==========================================================
package lb_map_pkg;

	// Address bits 23..16 select the region
	typedef enum logic [7:0] {
		REG_BANK = 8'h00,
		MIRROR   = 8'h05
	} region_e;

	// Address bits 3..0 inside the read-only register bank
	typedef enum logic [3:0] {
		HELLO0      = 4'h0,
		HELLO1      = 4'h1,
		HELLO2      = 4'h2,
		HELLO3      = 4'h3,
		FAULT_COUNT = 4'h4,
		UPTIME      = 4'h8,
		STATUS      = 4'h9
	} bank_reg_e;

	// Address bits 4..0 of a write to the MIRROR region
	typedef enum logic [4:0] {
		LED_USER  = 5'd1,
		LED1_DUTY = 5'd2,
		LED2_DUTY = 5'd3,
		MISC_CFG  = 5'd8
	} wr_reg_e;

endpackage

/* source/lb_ctl_pkg.sv */
// ==========================================================
// Control register set written by the host
// ==========================================================
package lb_ctl_pkg;

	// Duty factors are in units of 4 counts out of 1024
	typedef struct packed {
		logic       led_user;
		logic [7:0] led1_duty;
		logic [7:0] led2_duty;
		logic [7:0] misc_cfg;
	} ctl_regs_t;

endpackage

/* source/lb_bus_if.sv */
// ==========================================================
// Host local bus inside the slave: address, strobe, rd, data
// ==========================================================
`include "lb_slave_defs.svh"

interface lb_bus_if;

	logic [`LB_ADDR_W-1:0] addr;
	logic                  strobe;
	// High for a read, low for a write
	logic                  rd;
	logic [`LB_DATA_W-1:0] wdata;

	modport decoder (
		input addr,
		input strobe,
		input rd,
		input wdata
	);

	modport mirror (
		input addr,
		input wdata
	);

	modport reader (
		input addr,
		input strobe,
		input rd
	);

endinterface

/* source/lb_write_decode.sv */
// ==========================================================
// Write decoder: host writes into control registers and the
// mirror write strobe
// ==========================================================
`include "lb_slave_defs.svh"

module lb_write_decode
	import lb_map_pkg::*;
	import lb_ctl_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	lb_bus_if.decoder bus,
	output ctl_regs_t ctl,
	output logic      mirror_we
);

	logic local_write;

	// Only writes to the MIRROR region reach the control registers
	assign local_write = bus.strobe & ~bus.rd &
		(region_e'(bus.addr[23:16]) == MIRROR);

	// Every local write also lands in the mirror for readback
	assign mirror_we = local_write;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctl.led_user  <= 1'b0;
			ctl.led1_duty <= 8'd0;
			ctl.led2_duty <= 8'd0;
			ctl.misc_cfg  <= `MISC_DEFAULT;
		end else if (local_write) begin
			case (wr_reg_e'(bus.addr[4:0]))
				LED_USER: begin
					ctl.led_user <= bus.wdata[0];
				end
				LED1_DUTY: begin
					ctl.led1_duty <= bus.wdata[7:0];
				end
				LED2_DUTY: begin
					ctl.led2_duty <= bus.wdata[7:0];
				end
				MISC_CFG: begin
					ctl.misc_cfg <= bus.wdata[7:0];
				end
				// Other offsets only go to the mirror
				default: begin
				end
			endcase
		end
	end

endmodule

/* source/mirror_ram.sv */
// ==========================================================
// Mirror memory: 32 words, one write port, registered read
// ==========================================================
`include "lb_slave_defs.svh"

module mirror_ram (
	input  logic                  clk,
	lb_bus_if.mirror              bus,
	input  logic                  we,
	output logic [`LB_DATA_W-1:0] rdata
);

	localparam int DEPTH = 1 << `MIRROR_AW;

	logic [`LB_DATA_W-1:0] mem [DEPTH];
	logic [`MIRROR_AW-1:0] word_addr;

	// Write and read share the low address bits
	assign word_addr = bus.addr[`MIRROR_AW-1:0];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[word_addr] <= bus.wdata;
		end
	end

	// Read every cycle, the read pipeline picks the word when needed
	always_ff @(posedge clk) begin
		rdata <= mem[word_addr];
	end

endmodule

/* source/led_pwm.sv */
// ==========================================================
// LED PWM: free-running counter, uptime and two comparators
// ==========================================================
`include "lb_slave_defs.svh"

module led_pwm
	import lb_ctl_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  ctl_regs_t   ctl,
	output logic [31:0] uptime,
	output logic        led1,
	output logic        led2
);

	logic [`LED_CW-1:0] led_cc;
	logic               led_tick;

	// Carry out of the counter gives one tick per 1024 cycles
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_cc   <= '0;
			led_tick <= 1'b0;
			uptime   <= 32'd0;
			led1     <= 1'b0;
			led2     <= 1'b0;
		end else begin
			{led_tick, led_cc} <= {1'b0, led_cc} + (`LED_CW+1)'(1);
			if (led_tick) begin
				uptime <= uptime + 32'd1;
			end
			// High for 4*duty counts out of 1024
			led1 <= led_cc < {ctl.led1_duty, 2'b00};
			led2 <= led_cc < {ctl.led2_duty, 2'b00};
		end
	end

endmodule

/* source/lb_read_pipe.sv */
// ==========================================================
// Two-cycle read pipeline: register bank, fault counter and
// region select onto data_in
// ==========================================================
`include "lb_slave_defs.svh"

module lb_read_pipe
	import lb_map_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	lb_bus_if.reader              bus,
	input  logic                  fault,
	input  logic [31:0]           uptime,
	input  logic [7:0]            misc_cfg,
	input  logic [`LB_DATA_W-1:0] mirror_rdata,
	output logic [`LB_DATA_W-1:0] data_in
);

	logic                  do_rd;
	logic                  do_rd_r;
	logic                  do_rd_r2;
	region_e               region_r;
	logic [15:0]           fault_count;
	logic [`LB_DATA_W-1:0] bank_word;
	logic [`LB_DATA_W-1:0] read_word;

	assign do_rd = bus.strobe & bus.rd;

	// Cross-domain fault pulses wrap at 16 bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fault_count <= 16'd0;
		end else if (fault) begin
			fault_count <= fault_count + 16'd1;
		end
	end

	// Read cycle picks the bank word while the mirror reads
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (bank_reg_e'(bus.addr[3:0]))
				HELLO0:      bank_word <= `HELLO_0;
				HELLO1:      bank_word <= `HELLO_1;
				HELLO2:      bank_word <= `HELLO_2;
				HELLO3:      bank_word <= `HELLO_3;
				FAULT_COUNT: bank_word <= {16'd0, fault_count};
				UPTIME:      bank_word <= uptime;
				STATUS:      bank_word <= {24'd0, misc_cfg};
				default:     bank_word <= `BANK_FILL;
			endcase
		end
	end

	// Only the region bits are needed in the second cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			do_rd_r  <= 1'b0;
			do_rd_r2 <= 1'b0;
			region_r <= REG_BANK;
		end else begin
			do_rd_r  <= do_rd;
			do_rd_r2 <= do_rd_r;
			region_r <= region_e'(bus.addr[23:16]);
		end
	end

	// Second cycle selects the region
	always_ff @(posedge clk) begin
		if (do_rd_r) begin
			case (region_r)
				REG_BANK: read_word <= bank_word;
				MIRROR:   read_word <= mirror_rdata;
				default:  read_word <= `REGION_FILL;
			endcase
		end
	end

	// Output word holds until the next read completes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_in <= '0;
		end else if (do_rd_r2) begin
			data_in <= read_word;
		end
	end

endmodule

/* source/lb_slave_top.sv */
// ==========================================================
// Local-bus register slave top: host bus to control, mirror,
// register bank and LED PWM
// ==========================================================
`include "lb_slave_defs.svh"

module lb_slave_top
	import lb_ctl_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [`LB_ADDR_W-1:0] addr,
	input  logic                  control_strobe,
	input  logic                  control_rd,
	input  logic [`LB_DATA_W-1:0] data_out,
	output logic [`LB_DATA_W-1:0] data_in,
	input  logic                  xdomain_fault,
	output logic                  led_user_mode,
	output logic                  led1,
	output logic                  led2,
	output logic [7:0]            misc_cfg
);

	lb_bus_if bus ();

	ctl_regs_t             ctl;
	logic                  mirror_we;
	logic [`LB_DATA_W-1:0] mirror_rdata;
	logic [31:0]           uptime;

	// Host pins onto the internal bus
	assign bus.addr   = addr;
	assign bus.strobe = control_strobe;
	assign bus.rd     = control_rd;
	assign bus.wdata  = data_out;

	lb_write_decode write_decode_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.bus       (bus.decoder),
		.ctl       (ctl),
		.mirror_we (mirror_we)
	);

	mirror_ram mirror_i (
		.clk   (clk),
		.bus   (bus.mirror),
		.we    (mirror_we),
		.rdata (mirror_rdata)
	);

	led_pwm led_pwm_i (
		.clk    (clk),
		.arst_n (arst_n),
		.ctl    (ctl),
		.uptime (uptime),
		.led1   (led1),
		.led2   (led2)
	);

	lb_read_pipe read_pipe_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.bus          (bus.reader),
		.fault        (xdomain_fault),
		.uptime       (uptime),
		.misc_cfg     (ctl.misc_cfg),
		.mirror_rdata (mirror_rdata),
		.data_in      (data_in)
	);

	assign led_user_mode = ctl.led_user;
	assign misc_cfg      = ctl.misc_cfg;

endmodule

/* bench/lb_slave_tb.sv */
// ==========================================================
// Local-bus slave testbench, runs the stimulus file tests
// ==========================================================
`include "lb_slave_defs.svh"

module lb_slave_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk = 1'b0;
	logic                  arst_n;
	logic [`LB_ADDR_W-1:0] addr;
	logic                  control_strobe;
	logic                  control_rd;
	logic [`LB_DATA_W-1:0] data_out;
	logic [`LB_DATA_W-1:0] data_in;
	logic                  xdomain_fault;
	logic                  led_user_mode;
	logic                  led1;
	logic                  led2;
	logic [7:0]            misc_cfg;

	logic [7:0]  ops [$];
	logic [31:0] addrs [$];
	logic [31:0] datas [$];
	logic [31:0] exps [$];
	logic [31:0] lcg_state = 32'd24501;
	int          errors = 0;
	int          watchdog_cycles = 0;

	always #5 clk = ~clk;

	lb_slave_top dut_i (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// All bus tasks start and end on a falling edge
	task automatic bus_write(input logic [23:0] a, input logic [31:0] d);
		addr = a;
		data_out = d;
		control_rd = 1'b0;
		control_strobe = 1'b1;
		@(negedge clk);
		control_strobe = 1'b0;
	endtask

	task automatic bus_read(input logic [23:0] a, output logic [31:0] v);
		addr = a;
		control_rd = 1'b1;
		control_strobe = 1'b1;
		@(negedge clk);
		control_strobe = 1'b0;
		// Word lands on data_in two edges after the strobe edge
		repeat (2) @(negedge clk);
		v = data_in;
	endtask

	task automatic mirror_fill(input logic [23:0] base, input int count);
		logic [31:0] words [32];
		int          k;
		for (k = 0; k < count; k++) begin
			lcg_state = lcg_next(lcg_state);
			words[k] = lcg_state;
			bus_write(base + 24'(k), lcg_state);
		end
		// Back-to-back reads, each word checked three falling edges after its strobe
		for (k = 0; k < count + 3; k++) begin
			if (k >= 3) begin
				check_value("mirror word", data_in, words[k-3]);
			end
			if (k < count) begin
				addr = base + 24'(k);
				control_rd = 1'b1;
				control_strobe = 1'b1;
			end else begin
				control_strobe = 1'b0;
			end
			@(negedge clk);
		end
	endtask

	task automatic run_test(input logic [7:0] op, input logic [31:0] a,
		input logic [31:0] d, input logic [31:0] e);
		logic [31:0] v0;
		logic [31:0] v1;
		case (op)
			"W": bus_write(a[23:0], d);
			"R": begin
				bus_read(a[23:0], v0);
				check_value("read word", v0, e);
			end
			"F": begin
				repeat (d) begin
					xdomain_fault = 1'b1;
					@(negedge clk);
					xdomain_fault = 1'b0;
					@(negedge clk);
				end
				bus_read(a[23:0], v0);
				check_value("fault count", v0, e);
			end
			"M": mirror_fill(a[23:0], int'(d));
			"P": begin
				// Skip the edge where the comparator still sees the old duty
				@(negedge clk);
				v0 = 0;
				repeat (1024) begin
					v0 = v0 + ((a[1:0] == 2'd1) ? 32'(led1) : 32'(led2));
					@(negedge clk);
				end
				check_value("LED high count", v0, e);
			end
			"C": begin
				case (a[1:0])
					2'd0: v0 = 32'(led_user_mode);
					2'd1: v0 = 32'(misc_cfg);
					default: v0 = data_in;
				endcase
				check_value("pin value", v0, e);
			end
			"U": begin
				bus_read(a[23:0], v0);
				repeat (d - 3) @(negedge clk);
				bus_read(a[23:0], v1);
				check_value("uptime step", v1 - v0, e);
			end
			default: begin
				$display("Unknown operation %c in the stimulus file", op);
				errors++;
			end
		endcase
	endtask

	initial begin : watchdog
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Run timed out after %0d cycles without finishing", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int          fd;
		int          n;
		int          i;
		int          errs_before;
		int          n_fail;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		n_fail = 0;
		arst_n = 1'b0;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		fd = $fopen("bench/lb_slave_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %h %h %h", op, a, d, e);
					if (n == 4) begin
						ops.push_back(op);
						addrs.push_back(a);
						datas.push_back(d);
						exps.push_back(e);
					end else begin
						$display("Stimulus line could not be parsed: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		if (ops.size() == 0) begin
			$display("No tests were read from the stimulus file");
			errors++;
		end
		watchdog_cycles = ops.size() * 3000 + 1000;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		for (i = 0; i < ops.size(); i++) begin
			errs_before = errors;
			run_test(ops[i], addrs[i], datas[i], exps[i]);
			if (errors != errs_before) begin
				n_fail++;
			end
			$display("Test %0d %c %h: %s", i + 1, ops[i], addrs[i][23:0],
				(errors == errs_before) ? "pass" : "fail");
		end
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			ops.size(), ops.size() - n_fail, n_fail, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* bench/lb_slave_stim.txt */
# op addr data expected, all hex; W write, R read, F fault pulses then count read,
# M mirror fill of data words, P LED high cycles, C pin (0 user, 1 misc, 2 data_in), U uptime
C 000002 00000000 00000000
R 000000 00000000 48656c6c
R 000001 00000000 6f20776f
R 000002 00000000 726c6421
R 000003 00000000 283a3a29
R 000005 00000000 7a7a7a7a
R 000006 00000000 7a7a7a7a
R 000007 00000000 7a7a7a7a
R 030000 00000000 deadbeef
R 000009 00000000 0000005a
C 000000 00000000 00000000
C 000001 00000000 0000005a
W 050001 00000001 00000000
C 000000 00000000 00000001
W 050008 000000c3 00000000
C 000001 00000000 000000c3
R 000009 00000000 000000c3
F 000004 00000005 00000005
F 000004 00000003 00000008
M 050000 00000020 00000000
W 050002 00000040 00000000
R 050002 00000000 00000040
W 050003 000000c8 00000000
P 000001 00000000 00000100
P 000002 00000000 00000320
U 000008 00001000 00000004

/* lb_slave.f */
+incdir+source
source/lb_map_pkg.sv
source/lb_ctl_pkg.sv
source/lb_bus_if.sv
source/lb_write_decode.sv
source/mirror_ram.sv
source/led_pwm.sv
source/lb_read_pipe.sv
source/lb_slave_top.sv
bench/lb_slave_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the local-bus slave testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f lb_slave.f --top-module lb_slave_tb \
	&& ./obj_dir/Vlb_slave_tb | tee /dev/stderr | grep -q "TEST OK" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
